/* source/rob_pkg.sv */
package rob_pkg;

	// ==============================
	// Buffer geometry
	// ==============================

	// Number of reorder entries held at once
	localparam int rob_entries = 8;

	// Lowest address bit taking part in the line compare, so a line is 64 bytes
	localparam int line_lsb = 6;

	// ==============================
	// Shared types
	// ==============================

	// Index of one reorder slot
	typedef logic [2:0] slot_t;

	// Program-order stamp, wraps and is compared by wrapped difference
	typedef logic [7:0] seq_t;

	// Operand address as known at enqueue
	typedef logic [31:0] addr_t;

	// Instruction class as seen by the scheduler
	typedef enum logic [1:0] {
		kind_alu    = 2'd0,
		kind_branch = 2'd1,
		kind_load   = 2'd2,
		kind_store  = 2'd3
	} kind_t;

	// True when stamp a is older than stamp b
	// With at most eight live entries the wrapped difference never exceeds half the range
	function automatic logic seq_older(seq_t a, seq_t b);
		seq_t diff;
		diff = a - b;
		return diff[$bits(seq_t)-1];
	endfunction

endpackage

/* source/reorder_buffer.sv */
`timescale 1ns/1ns

module reorder_buffer (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       enq,
	input  rob_pkg::slot_t                             enq_slot,
	input  rob_pkg::kind_t                             enq_kind,
	input  rob_pkg::addr_t                             enq_addr,
	input  logic                                       enq_args_ready,
	input  logic                                       wake,
	input  rob_pkg::slot_t                             wake_slot,
	input  logic                                       issue,
	input  rob_pkg::slot_t                             issue_slot,
	input  logic                                       done,
	input  rob_pkg::slot_t                             done_slot,
	input  logic                                       retire,
	input  rob_pkg::slot_t                             retire_slot,
	output logic [rob_pkg::rob_entries-1:0]            entry_valid,
	output logic [rob_pkg::rob_entries-1:0]            entry_issued,
	output logic [rob_pkg::rob_entries-1:0]            entry_executed,
	output logic [rob_pkg::rob_entries-1:0]            entry_ready,
	output rob_pkg::kind_t [rob_pkg::rob_entries-1:0]  entry_kind,
	output rob_pkg::addr_t [rob_pkg::rob_entries-1:0]  entry_addr,
	output rob_pkg::seq_t [rob_pkg::rob_entries-1:0]   entry_seq
);

	// Stamp handed to the next enqueued instruction
	rob_pkg::seq_t seq_cnt;

	// ==============================
	// Per-slot status flags
	// ==============================

	// Each slot walks valid, ready, issued, executed and is then cleared by retire
	// The free-slot chooser never offers a live slot, so enqueue and retire
	// cannot land on the same slot in one cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			entry_valid    <= '0;
			entry_issued   <= '0;
			entry_executed <= '0;
			entry_ready    <= '0;
		end else begin
			for (int i = 0; i < rob_pkg::rob_entries; i++) begin
				// Operands arrived for a waiting entry
				if (wake && wake_slot == rob_pkg::slot_t'(i)) begin
					entry_ready[i] <= 1'b1;
				end
				// Scheduler sent this entry to execution
				if (issue && issue_slot == rob_pkg::slot_t'(i)) begin
					entry_issued[i] <= 1'b1;
				end
				// Execution side reports completion
				if (done && done_slot == rob_pkg::slot_t'(i)) begin
					entry_executed[i] <= 1'b1;
				end
				// Retirement frees the slot and drops every flag
				if (retire && retire_slot == rob_pkg::slot_t'(i)) begin
					entry_valid[i]    <= 1'b0;
					entry_issued[i]   <= 1'b0;
					entry_executed[i] <= 1'b0;
					entry_ready[i]    <= 1'b0;
				end
				// A new instruction starts fresh, ready only if its operands are
				if (enq && enq_slot == rob_pkg::slot_t'(i)) begin
					entry_valid[i]    <= 1'b1;
					entry_issued[i]   <= 1'b0;
					entry_executed[i] <= 1'b0;
					entry_ready[i]    <= enq_args_ready;
				end
			end
		end
	end

	// ==============================
	// Sequence counter
	// ==============================

	// Advances once per accepted instruction
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			seq_cnt <= '0;
		end else if (enq) begin
			seq_cnt <= seq_cnt + rob_pkg::seq_t'(1);
		end
	end

	// ==============================
	// Entry payload
	// ==============================

	// Kind, address and stamp are only looked at while the slot is valid
	always_ff @(posedge clk) begin
		if (enq) begin
			entry_kind[enq_slot] <= enq_kind;
			entry_addr[enq_slot] <= enq_addr;
			entry_seq[enq_slot]  <= seq_cnt;
		end
	end

endmodule

/* source/mem_order_queue.sv */
`timescale 1ns/1ns

module mem_order_queue (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        enq,
	input  rob_pkg::slot_t                              enq_slot,
	input  rob_pkg::kind_t                              enq_kind,
	input  logic                                        issue,
	input  rob_pkg::slot_t                              issue_slot,
	output logic [rob_pkg::rob_entries-1:0]             memo_valid,
	output rob_pkg::slot_t [rob_pkg::rob_entries-1:0]   memo_slot
);

	// Position 0 holds the oldest memory operation not yet issued
	logic [rob_pkg::rob_entries-1:0]           nxt_valid;
	rob_pkg::slot_t [rob_pkg::rob_entries-1:0] nxt_slot;
	logic                                      hit;
	logic [3:0]                                hit_pos;
	logic [3:0]                                count;
	logic [3:0]                                tail;
	logic                                      is_mem;

	assign is_mem = (enq_kind == rob_pkg::kind_load) || (enq_kind == rob_pkg::kind_store);

	always_comb begin
		hit       = 1'b0;
		hit_pos   = '0;
		count     = '0;
		nxt_valid = memo_valid;
		nxt_slot  = memo_slot;
		// Find where the issued slot sits, if it is a memory operation at all
		for (int i = 0; i < rob_pkg::rob_entries; i++) begin
			if (issue && !hit && memo_valid[i] && memo_slot[i] == issue_slot) begin
				hit     = 1'b1;
				hit_pos = 4'(i);
			end
			count = count + 4'(memo_valid[i]);
		end
		// Close the gap so age order stays contiguous from position 0
		for (int i = 0; i < rob_pkg::rob_entries - 1; i++) begin
			if (hit && 4'(i) >= hit_pos) begin
				nxt_valid[i] = memo_valid[i+1];
				nxt_slot[i]  = memo_slot[i+1];
			end
		end
		if (hit) begin
			nxt_valid[rob_pkg::rob_entries-1] = 1'b0;
		end
		// New arrival goes behind everything left after the shift
		tail = count - 4'(hit);
		if (enq && is_mem && tail < 4'(rob_pkg::rob_entries)) begin
			nxt_valid[tail[2:0]] = 1'b1;
			nxt_slot[tail[2:0]]  = enq_slot;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			memo_valid <= '0;
		end else begin
			memo_valid <= nxt_valid;
		end
	end

	// Slot numbers mean nothing without their valid bit
	always_ff @(posedge clk) begin
		memo_slot <= nxt_slot;
	end

endmodule

/* source/issue_select.sv */
`timescale 1ns/1ns

module issue_select (
	input  logic                                        strict,
	input  logic [rob_pkg::rob_entries-1:0]             entry_valid,
	input  logic [rob_pkg::rob_entries-1:0]             entry_issued,
	input  logic [rob_pkg::rob_entries-1:0]             entry_ready,
	input  rob_pkg::kind_t [rob_pkg::rob_entries-1:0]   entry_kind,
	input  rob_pkg::addr_t [rob_pkg::rob_entries-1:0]   entry_addr,
	input  rob_pkg::seq_t [rob_pkg::rob_entries-1:0]    entry_seq,
	input  logic [rob_pkg::rob_entries-1:0]             memo_valid,
	input  rob_pkg::slot_t [rob_pkg::rob_entries-1:0]   memo_slot,
	output logic                                        exec_valid,
	output rob_pkg::slot_t                              exec_slot
);

	localparam int addr_msb = $bits(rob_pkg::addr_t) - 1;

	logic           mem_sel;
	rob_pkg::slot_t mem_slot;
	logic           oth_sel;
	rob_pkg::slot_t oth_slot;
	logic           older_mem;
	logic           line_hit;
	logic           load_ok;
	rob_pkg::slot_t cur;
	rob_pkg::slot_t prv;
	logic           head_older;

	// ==============================
	// Memory pass
	// ==============================

	// Walk the queue oldest first; the first entry that may legally go wins
	always_comb begin
		mem_sel   = 1'b0;
		mem_slot  = '0;
		older_mem = 1'b0;
		line_hit  = 1'b0;
		load_ok   = 1'b0;
		cur       = '0;
		prv       = '0;
		for (int p = 0; p < rob_pkg::rob_entries; p++) begin
			if (memo_valid[p]) begin
				cur = memo_slot[p];
				if (entry_valid[cur] && !entry_issued[cur]) begin
					// Any older unissued store touching the same 64-byte line blocks a load
					line_hit = 1'b0;
					for (int q = 0; q < rob_pkg::rob_entries; q++) begin
						prv = memo_slot[q];
						if (q < p && memo_valid[q] && !entry_issued[prv] &&
							entry_kind[prv] == rob_pkg::kind_store &&
							entry_addr[prv][addr_msb:rob_pkg::line_lsb] ==
							entry_addr[cur][addr_msb:rob_pkg::line_lsb]) begin
							line_hit = 1'b1;
						end
					end
					// Strict mode lets only the head of the unissued memory stream go
					load_ok = strict ? !older_mem : !line_hit;
					if (!mem_sel && entry_ready[cur]) begin
						if (entry_kind[cur] == rob_pkg::kind_store && !older_mem) begin
							mem_sel  = 1'b1;
							mem_slot = cur;
						end else if (entry_kind[cur] == rob_pkg::kind_load && load_ok) begin
							mem_sel  = 1'b1;
							mem_slot = cur;
						end
					end
					// Waiting entries still count as older work for everyone behind
					older_mem = 1'b1;
				end
			end
		end
	end

	// ==============================
	// Non-memory pass
	// ==============================

	// Queue head is the oldest unissued memory operation, since issue removes entries
	always_comb begin
		oth_sel    = 1'b0;
		oth_slot   = '0;
		head_older = 1'b0;
		for (int i = 0; i < rob_pkg::rob_entries; i++) begin
			head_older = memo_valid[0] &&
				!rob_pkg::seq_older(entry_seq[i], entry_seq[memo_slot[0]]);
			if (!oth_sel && entry_valid[i] && !entry_issued[i] && entry_ready[i] &&
				(entry_kind[i] == rob_pkg::kind_alu || entry_kind[i] == rob_pkg::kind_branch) &&
				!(strict && head_older)) begin
				oth_sel  = 1'b1;
				oth_slot = rob_pkg::slot_t'(i);
			end
		end
	end

	// Memory operations take priority so the ordered stream keeps moving
	assign exec_valid = mem_sel | oth_sel;
	assign exec_slot  = mem_sel ? mem_slot : oth_slot;

endmodule

/* source/rob_schedule.sv */
`timescale 1ns/1ns

module rob_schedule (
	input  logic                                        clk,
	input  logic                                        rst_n,
	input  logic                                        strict,
	input  logic [rob_pkg::rob_entries-1:0]             entry_valid,
	input  logic [rob_pkg::rob_entries-1:0]             entry_issued,
	input  logic [rob_pkg::rob_entries-1:0]             entry_executed,
	input  logic [rob_pkg::rob_entries-1:0]             entry_ready,
	input  rob_pkg::kind_t [rob_pkg::rob_entries-1:0]   entry_kind,
	input  rob_pkg::addr_t [rob_pkg::rob_entries-1:0]   entry_addr,
	input  rob_pkg::seq_t [rob_pkg::rob_entries-1:0]    entry_seq,
	input  logic [rob_pkg::rob_entries-1:0]             memo_valid,
	input  rob_pkg::slot_t [rob_pkg::rob_entries-1:0]   memo_slot,
	output logic                                        open_buf,
	output rob_pkg::slot_t                              open_slot,
	output logic                                        exec_valid,
	output rob_pkg::slot_t                              exec_slot,
	output logic                                        retire_valid,
	output rob_pkg::slot_t                              retire_slot
);

	logic                            last_open;
	rob_pkg::slot_t                  last_slot;
	logic [rob_pkg::rob_entries-1:0] blocked;
	logic                            ret_found;

	// ==============================
	// Free-slot chooser
	// ==============================

	// Slot offered last cycle stays locked out for one cycle
	always_comb begin
		open_buf  = 1'b0;
		open_slot = '0;
		for (int i = 0; i < rob_pkg::rob_entries; i++) begin
			blocked[i] = entry_valid[i] || (last_open && last_slot == rob_pkg::slot_t'(i));
			if (!open_buf && !blocked[i]) begin
				open_buf  = 1'b1;
				open_slot = rob_pkg::slot_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_open <= 1'b0;
		end else begin
			last_open <= open_buf;
		end
	end

	// Only read while last_open is set
	always_ff @(posedge clk) begin
		last_slot <= open_slot;
	end

	// ==============================
	// Retire chooser
	// ==============================

	// Oldest live entry by stamp; it retires only once executed
	always_comb begin
		ret_found   = 1'b0;
		retire_slot = '0;
		for (int i = 0; i < rob_pkg::rob_entries; i++) begin
			if (entry_valid[i] &&
				(!ret_found || rob_pkg::seq_older(entry_seq[i], entry_seq[retire_slot]))) begin
				ret_found   = 1'b1;
				retire_slot = rob_pkg::slot_t'(i);
			end
		end
		retire_valid = ret_found && entry_executed[retire_slot];
	end

	issue_select u_issue_select (
		.strict       (strict),
		.entry_valid  (entry_valid),
		.entry_issued (entry_issued),
		.entry_ready  (entry_ready),
		.entry_kind   (entry_kind),
		.entry_addr   (entry_addr),
		.entry_seq    (entry_seq),
		.memo_valid   (memo_valid),
		.memo_slot    (memo_slot),
		.exec_valid   (exec_valid),
		.exec_slot    (exec_slot)
	);

endmodule

/* source/rob_core.sv */
`timescale 1ns/1ns

module rob_core (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           enq,
	input  rob_pkg::kind_t enq_kind,
	input  rob_pkg::addr_t enq_addr,
	input  logic           enq_args_ready,
	input  logic           wake,
	input  rob_pkg::slot_t wake_slot,
	input  logic           done,
	input  rob_pkg::slot_t done_slot,
	input  logic           strict,
	output logic           open_buf,
	output rob_pkg::slot_t open_slot,
	output logic           exec_valid,
	output rob_pkg::slot_t exec_slot,
	output rob_pkg::seq_t  exec_seq,
	output rob_pkg::kind_t exec_kind,
	output rob_pkg::addr_t exec_addr,
	output logic           retire_valid,
	output rob_pkg::slot_t retire_slot,
	output rob_pkg::seq_t  retire_seq
);

	logic [rob_pkg::rob_entries-1:0]           entry_valid;
	logic [rob_pkg::rob_entries-1:0]           entry_issued;
	logic [rob_pkg::rob_entries-1:0]           entry_executed;
	logic [rob_pkg::rob_entries-1:0]           entry_ready;
	rob_pkg::kind_t [rob_pkg::rob_entries-1:0] entry_kind;
	rob_pkg::addr_t [rob_pkg::rob_entries-1:0] entry_addr;
	rob_pkg::seq_t [rob_pkg::rob_entries-1:0]  entry_seq;
	logic [rob_pkg::rob_entries-1:0]           memo_valid;
	rob_pkg::slot_t [rob_pkg::rob_entries-1:0] memo_slot;
	logic                                      enq_ok;

	// An enqueue counts only while a slot is on offer
	assign enq_ok = enq & open_buf;

	reorder_buffer u_reorder_buffer (
		.clk            (clk),
		.rst_n          (rst_n),
		.enq            (enq_ok),
		.enq_slot       (open_slot),
		.enq_kind       (enq_kind),
		.enq_addr       (enq_addr),
		.enq_args_ready (enq_args_ready),
		.wake           (wake),
		.wake_slot      (wake_slot),
		.issue          (exec_valid),
		.issue_slot     (exec_slot),
		.done           (done),
		.done_slot      (done_slot),
		.retire         (retire_valid),
		.retire_slot    (retire_slot),
		.entry_valid    (entry_valid),
		.entry_issued   (entry_issued),
		.entry_executed (entry_executed),
		.entry_ready    (entry_ready),
		.entry_kind     (entry_kind),
		.entry_addr     (entry_addr),
		.entry_seq      (entry_seq)
	);

	mem_order_queue u_mem_order_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.enq        (enq_ok),
		.enq_slot   (open_slot),
		.enq_kind   (enq_kind),
		.issue      (exec_valid),
		.issue_slot (exec_slot),
		.memo_valid (memo_valid),
		.memo_slot  (memo_slot)
	);

	rob_schedule u_rob_schedule (
		.clk            (clk),
		.rst_n          (rst_n),
		.strict         (strict),
		.entry_valid    (entry_valid),
		.entry_issued   (entry_issued),
		.entry_executed (entry_executed),
		.entry_ready    (entry_ready),
		.entry_kind     (entry_kind),
		.entry_addr     (entry_addr),
		.entry_seq      (entry_seq),
		.memo_valid     (memo_valid),
		.memo_slot      (memo_slot),
		.open_buf       (open_buf),
		.open_slot      (open_slot),
		.exec_valid     (exec_valid),
		.exec_slot      (exec_slot),
		.retire_valid   (retire_valid),
		.retire_slot    (retire_slot)
	);

	// Payload of the chosen slots goes out with the strobes
	assign exec_seq   = entry_seq[exec_slot];
	assign exec_kind  = entry_kind[exec_slot];
	assign exec_addr  = entry_addr[exec_slot];
	assign retire_seq = entry_seq[retire_slot];

endmodule

/* tb/rob_core_properties.sv */
`timescale 1ns/1ns

module rob_core_properties (
	input logic                            clk,
	input logic                            rst_n,
	input logic                            open_buf,
	input rob_pkg::slot_t                  open_slot,
	input logic [rob_pkg::rob_entries-1:0] entry_valid,
	input logic [rob_pkg::rob_entries-1:0] entry_issued,
	input logic [rob_pkg::rob_entries-1:0] entry_executed,
	input logic                            exec_valid,
	input rob_pkg::slot_t                  exec_slot,
	input logic                            retire_valid,
	input rob_pkg::slot_t                  retire_slot
);

	// ==============================
	// Allocation and issue rules
	// ==============================

	// A slot on offer is always free
	open_is_free: assert property (@(posedge clk) disable iff (!rst_n)
		open_buf |-> !entry_valid[open_slot])
		else $error("open_slot %0d names a live entry", open_slot);

	// Only a live entry that has not gone yet may issue
	exec_is_legal: assert property (@(posedge clk) disable iff (!rst_n)
		exec_valid |-> entry_valid[exec_slot] && !entry_issued[exec_slot])
		else $error("exec_slot %0d is not a live unissued entry", exec_slot);

	// Retirement waits for completion
	retire_is_done: assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid |-> entry_executed[retire_slot])
		else $error("retire_slot %0d has not executed", retire_slot);

endmodule

bind rob_core rob_core_properties u_rob_core_properties (
	.clk            (clk),
	.rst_n          (rst_n),
	.open_buf       (open_buf),
	.open_slot      (open_slot),
	.entry_valid    (entry_valid),
	.entry_issued   (entry_issued),
	.entry_executed (entry_executed),
	.exec_valid     (exec_valid),
	.exec_slot      (exec_slot),
	.retire_valid   (retire_valid),
	.retire_slot    (retire_slot)
);

/* tb/rob_checker.sv */
`timescale 1ns/1ns

module rob_checker (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           enq,
	input  rob_pkg::kind_t enq_kind,
	input  rob_pkg::addr_t enq_addr,
	input  logic           enq_args_ready,
	input  logic           wake,
	input  rob_pkg::slot_t wake_slot,
	input  logic           done,
	input  rob_pkg::slot_t done_slot,
	input  logic           strict,
	input  logic           open_buf,
	input  rob_pkg::slot_t open_slot,
	input  logic           exec_valid,
	input  rob_pkg::slot_t exec_slot,
	input  rob_pkg::seq_t  exec_seq,
	input  rob_pkg::kind_t exec_kind,
	input  rob_pkg::addr_t exec_addr,
	input  logic           retire_valid,
	input  rob_pkg::slot_t retire_slot,
	input  rob_pkg::seq_t  retire_seq,
	input  logic           test_end,
	input  int             test_num,
	output int             error_count,
	output int             tests_done,
	output int             tests_failed
);

	// Model of every instruction by its sequence number
	rob_pkg::kind_t ent_kind   [256];
	rob_pkg::addr_t ent_addr   [256];
	logic           ent_ready  [256];
	logic           ent_issued [256];
	logic           ent_exec   [256];

	// Which sequence number each slot holds, and whether it is live
	rob_pkg::seq_t  slot_seq  [rob_pkg::rob_entries];
	logic           slot_live [rob_pkg::rob_entries];

	rob_pkg::seq_t  next_seq;
	rob_pkg::seq_t  next_ret;
	logic           prev_open;
	rob_pkg::slot_t prev_slot;
	int             test_errors;

	task automatic log_failure(input string msg);
		$display("Fail %0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	function automatic logic is_mem(input rob_pkg::kind_t kind);
		return kind == rob_pkg::kind_load || kind == rob_pkg::kind_store;
	endfunction

	// A line is 64 bytes, so the low six address bits do not count
	function automatic logic same_line(input rob_pkg::addr_t a, input rob_pkg::addr_t b);
		return a[31:6] == b[31:6];
	endfunction

	// ==============================
	// Slot offer and fullness
	// ==============================

	task automatic check_offer();
		int live;
		live = 0;
		for (int i = 0; i < rob_pkg::rob_entries; i++) begin
			live += int'(slot_live[i]);
		end
		if (live == rob_pkg::rob_entries && open_buf) begin
			log_failure("open_buf is high while all eight entries are live");
		end
		if (open_buf && slot_live[open_slot]) begin
			log_failure($sformatf("open_slot %0d names a live entry", open_slot));
		end
		if (open_buf && prev_open && open_slot == prev_slot) begin
			log_failure($sformatf("open_slot %0d repeats the previous offer", open_slot));
		end
		// The oldest entry must leave one cycle after its completion was seen
		if (next_ret != next_seq && ent_exec[next_ret] && !retire_valid) begin
			log_failure($sformatf("seq %0d is executed and oldest but did not retire", next_ret));
		end
	endtask

	// ==============================
	// Issue legality
	// ==============================

	task automatic check_issue();
		rob_pkg::seq_t s;
		rob_pkg::seq_t o;
		s = slot_seq[exec_slot];
		if (!slot_live[exec_slot] || ent_issued[s]) begin
			log_failure($sformatf("exec_slot %0d is not a live unissued entry", exec_slot));
			return;
		end
		if (!ent_ready[s]) begin
			log_failure($sformatf("seq %0d issued before its wake pulse", s));
		end
		if (exec_seq != s) begin
			log_failure($sformatf("exec_seq %0d, expected %0d", exec_seq, s));
		end
		if (exec_kind != ent_kind[s] || exec_addr != ent_addr[s]) begin
			log_failure($sformatf("seq %0d issued as kind %0d addr %h, expected kind %0d addr %h",
				s, exec_kind, exec_addr, ent_kind[s], ent_addr[s]));
		end
		// Every entry between the retire point and this one is older
		for (o = next_ret; o != s; o++) begin
			if (!ent_issued[o] && is_mem(ent_kind[o])) begin
				if (ent_kind[s] == rob_pkg::kind_store) begin
					log_failure($sformatf("store seq %0d passed memory seq %0d", s, o));
				end else if (strict) begin
					log_failure($sformatf("strict mode let seq %0d pass memory seq %0d", s, o));
				end else if (ent_kind[s] == rob_pkg::kind_load &&
					ent_kind[o] == rob_pkg::kind_store && same_line(ent_addr[s], ent_addr[o])) begin
					log_failure($sformatf("load seq %0d passed store seq %0d on its line", s, o));
				end
			end
		end
		ent_issued[s] = 1'b1;
	endtask

	// ==============================
	// Retirement order
	// ==============================

	task automatic check_retire();
		if (retire_seq != next_ret) begin
			log_failure($sformatf("retire_seq %0d, expected %0d", retire_seq, next_ret));
		end else if (!slot_live[retire_slot] || slot_seq[retire_slot] != next_ret) begin
			log_failure($sformatf("retire_slot %0d does not hold seq %0d", retire_slot, next_ret));
		end else if (!ent_issued[next_ret] || !ent_exec[next_ret]) begin
			log_failure($sformatf("seq %0d retired before it executed", next_ret));
		end
		slot_live[retire_slot] = 1'b0;
		next_ret++;
	endtask

	task automatic close_test();
		if (next_ret != next_seq) begin
			log_failure("entries are still in the buffer at the end of the test");
		end
		tests_done++;
		if (test_errors == 0) begin
			$display("Test %0d passed", test_num);
		end else begin
			$display("Test %0d failed with %0d errors", test_num, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			next_seq     = '0;
			next_ret     = '0;
			prev_open    = 1'b0;
			prev_slot    = '0;
			test_errors  = 0;
			error_count  = 0;
			tests_done   = 0;
			tests_failed = 0;
			for (int i = 0; i < rob_pkg::rob_entries; i++) begin
				slot_live[i] = 1'b0;
			end
		end else begin
			check_offer();
			if (exec_valid) begin
				check_issue();
			end
			if (retire_valid) begin
				check_retire();
			end
			if (done) begin
				if (!slot_live[done_slot] || !ent_issued[slot_seq[done_slot]]) begin
					log_failure($sformatf("done for slot %0d, which is not in execution", done_slot));
				end
				ent_exec[slot_seq[done_slot]] = 1'b1;
			end
			if (wake) begin
				ent_ready[slot_seq[wake_slot]] = 1'b1;
			end
			// New entry becomes visible to the scheduler after this edge
			if (enq && open_buf) begin
				slot_seq[open_slot]  = next_seq;
				slot_live[open_slot] = 1'b1;
				ent_kind[next_seq]   = enq_kind;
				ent_addr[next_seq]   = enq_addr;
				ent_ready[next_seq]  = enq_args_ready;
				ent_issued[next_seq] = 1'b0;
				ent_exec[next_seq]   = 1'b0;
				next_seq++;
			end
			if (test_end) begin
				close_test();
			end
			prev_open = open_buf;
			prev_slot = open_slot;
		end
	end

endmodule

/* tb/rob_core_tb.sv */
`timescale 1ns/1ns

module rob_core_tb;

	localparam int n_rows   = 24;
	localparam int n_groups = 4;

	logic           clk;
	logic           rst_n;
	logic           enq;
	rob_pkg::kind_t enq_kind;
	rob_pkg::addr_t enq_addr;
	logic           enq_args_ready;
	logic           wake;
	rob_pkg::slot_t wake_slot;
	logic           done;
	rob_pkg::slot_t done_slot;
	logic           strict;
	logic           open_buf;
	rob_pkg::slot_t open_slot;
	logic           exec_valid;
	rob_pkg::slot_t exec_slot;
	rob_pkg::seq_t  exec_seq;
	rob_pkg::kind_t exec_kind;
	rob_pkg::addr_t exec_addr;
	logic           retire_valid;
	rob_pkg::slot_t retire_slot;
	rob_pkg::seq_t  retire_seq;
	logic           test_end;
	int             test_num;
	int             error_count;
	int             tests_done;
	int             tests_failed;

	// Stimulus table, one row per instruction
	rob_pkg::kind_t tbl_kind   [n_rows];
	rob_pkg::addr_t tbl_addr   [n_rows];
	logic           tbl_ready  [n_rows];
	logic           tbl_strict [n_rows];
	int             tbl_count;

	// First row of each group, closed by the row count
	int group_first [n_groups+1] = '{0, 5, 10, 15, 24};

	// Execution side state, advanced on the rising edge
	int             busy      [rob_pkg::rob_entries];
	int             wake_wait [rob_pkg::rob_entries];
	logic           done_req;
	rob_pkg::slot_t done_req_slot;
	logic           wake_req;
	rob_pkg::slot_t wake_req_slot;
	int             enq_total;
	int             ret_total;

	rob_core uut (.*);

	rob_checker u_checker (.*);

	// ==============================
	// Clock and stimulus table
	// ==============================

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	task automatic add_row(input rob_pkg::kind_t kind, input rob_pkg::addr_t addr,
		input logic ready, input logic strict_mode);
		tbl_kind[tbl_count]   = kind;
		tbl_addr[tbl_count]   = addr;
		tbl_ready[tbl_count]  = ready;
		tbl_strict[tbl_count] = strict_mode;
		tbl_count++;
	endtask

	task automatic fill_table();
		tbl_count = 0;
		// Loads around a late store, one sharing its line and one not
		add_row(rob_pkg::kind_store,  32'h0000_1000, 1'b0, 1'b0);
		add_row(rob_pkg::kind_load,   32'h0000_1010, 1'b1, 1'b0);
		add_row(rob_pkg::kind_load,   32'h0000_2000, 1'b1, 1'b0);
		add_row(rob_pkg::kind_alu,    32'h0000_0000, 1'b1, 1'b0);
		add_row(rob_pkg::kind_store,  32'h0000_2040, 1'b1, 1'b0);
		// Strict mode with a slow load at the head of the memory stream
		add_row(rob_pkg::kind_load,   32'h0000_3000, 1'b0, 1'b1);
		add_row(rob_pkg::kind_alu,    32'h0000_0000, 1'b1, 1'b1);
		add_row(rob_pkg::kind_store,  32'h0000_3100, 1'b1, 1'b1);
		add_row(rob_pkg::kind_load,   32'h0000_3200, 1'b1, 1'b1);
		add_row(rob_pkg::kind_branch, 32'h0000_0000, 1'b1, 1'b1);
		// Wake pulses, and a load stuck behind a waiting store on its line
		add_row(rob_pkg::kind_alu,    32'h0000_0000, 1'b0, 1'b0);
		add_row(rob_pkg::kind_branch, 32'h0000_0000, 1'b0, 1'b0);
		add_row(rob_pkg::kind_load,   32'h0000_4000, 1'b1, 1'b0);
		add_row(rob_pkg::kind_store,  32'h0000_4080, 1'b0, 1'b0);
		add_row(rob_pkg::kind_load,   32'h0000_4090, 1'b1, 1'b0);
		// More rows than entries, so the buffer fills behind a slow head
		add_row(rob_pkg::kind_store,  32'h0000_5000, 1'b0, 1'b0);
		add_row(rob_pkg::kind_load,   32'h0000_5008, 1'b1, 1'b0);
		add_row(rob_pkg::kind_alu,    32'h0000_0000, 1'b1, 1'b0);
		add_row(rob_pkg::kind_alu,    32'h0000_0000, 1'b1, 1'b0);
		add_row(rob_pkg::kind_branch, 32'h0000_0000, 1'b1, 1'b0);
		add_row(rob_pkg::kind_load,   32'h0000_6000, 1'b1, 1'b0);
		add_row(rob_pkg::kind_alu,    32'h0000_0000, 1'b0, 1'b0);
		add_row(rob_pkg::kind_store,  32'h0000_6040, 1'b1, 1'b0);
		add_row(rob_pkg::kind_alu,    32'h0000_0000, 1'b1, 1'b0);
	endtask

	// ==============================
	// Execution side model
	// ==============================

	// Counts down completion and wake delays; each finished slot reports one per cycle
	initial begin
		void'($urandom(53));
		done_req      = 1'b0;
		done_req_slot = '0;
		wake_req      = 1'b0;
		wake_req_slot = '0;
		enq_total     = 0;
		ret_total     = 0;
		for (int i = 0; i < rob_pkg::rob_entries; i++) begin
			busy[i]      = 0;
			wake_wait[i] = 0;
		end
		forever begin
			@(posedge clk);
			if (rst_n) begin
				done_req = 1'b0;
				wake_req = 1'b0;
				for (int i = 0; i < rob_pkg::rob_entries; i++) begin
					if (busy[i] == 1 && !done_req) begin
						done_req      = 1'b1;
						done_req_slot = rob_pkg::slot_t'(i);
						busy[i]       = 0;
					end else if (busy[i] > 1) begin
						busy[i]--;
					end
					if (wake_wait[i] == 1 && !wake_req) begin
						wake_req      = 1'b1;
						wake_req_slot = rob_pkg::slot_t'(i);
						wake_wait[i]  = 0;
					end else if (wake_wait[i] > 1) begin
						wake_wait[i]--;
					end
				end
				// A new issue starts its own random execution time
				if (exec_valid) begin
					busy[exec_slot] = $urandom_range(6, 1);
				end
				if (enq && open_buf) begin
					enq_total++;
					if (!enq_args_ready) begin
						wake_wait[open_slot] = 3;
					end
				end
				if (retire_valid) begin
					ret_total++;
				end
			end
		end
	end

	// Completion and wake strobes change only on the falling edge
	always @(negedge clk) begin
		done      = done_req;
		done_slot = done_req_slot;
		wake      = wake_req;
		wake_slot = wake_req_slot;
	end

	// ==============================
	// Test sequence
	// ==============================

	// One group per test, then wait for the buffer to drain
	task automatic run_group(input int g);
		int row;
		row = group_first[g];
		@(negedge clk);
		strict = tbl_strict[row];
		while (row < group_first[g+1]) begin
			@(negedge clk);
			if (open_buf) begin
				enq            = 1'b1;
				enq_kind       = tbl_kind[row];
				enq_addr       = tbl_addr[row];
				enq_args_ready = tbl_ready[row];
				row++;
			end else begin
				enq = 1'b0;
			end
		end
		@(negedge clk);
		enq = 1'b0;
		while (ret_total != enq_total) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		test_num = g;
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
	endtask

	initial begin
		rst_n          = 1'b0;
		enq            = 1'b0;
		enq_kind       = rob_pkg::kind_alu;
		enq_addr       = '0;
		enq_args_ready = 1'b0;
		wake           = 1'b0;
		wake_slot      = '0;
		done           = 1'b0;
		done_slot      = '0;
		strict         = 1'b0;
		test_end       = 1'b0;
		test_num       = 0;
		fill_table();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int g = 0; g < n_groups; g++) begin
			run_group(g);
		end
		@(negedge clk);
		$display("Summary: %0d tests run, %0d failed, %0d errors",
			tests_done, tests_failed, error_count);
		if (tests_done == n_groups && tests_failed == 0 && error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Forty cycles per row is far more than any row needs to retire
	initial begin
		repeat (5 + n_rows * 40 + 200) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", 5 + n_rows * 40 + 200);
		$display("tests failed");
		$finish;
	end

endmodule

/* rob_core.f */
source/rob_pkg.sv
source/reorder_buffer.sv
source/mem_order_queue.sv
source/issue_select.sv
source/rob_schedule.sv
source/rob_core.sv
tb/rob_core_properties.sv
tb/rob_checker.sv
tb/rob_core_tb.sv

/* Makefile */
TOP := rob_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f rob_core.f

# The run passes only if the pass line shows up in the output
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f rob_core.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
